// File: fifo_consts.svh
// FIFO_DEPTH must equal 2**FIFO_ADDR_W since the pointers wrap on their own width
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// --------------------------------------------------
// storage geometry
// --------------------------------------------------

// bits per stored word
`define FIFO_DATA_W 16

// words in the single-port ram
`define FIFO_DEPTH 16

// pointer width, log2 of the depth
`define FIFO_ADDR_W 4

`endif

// File: fifo_pkg.sv
// shared types only, widths follow the macros in the consts header
`default_nettype none

`include "fifo_consts.svh"

package fifo_pkg;

   // one payload word
   typedef logic [`FIFO_DATA_W-1:0] fifo_word_t;

   // operation the memory port performs this cycle
   typedef enum logic [1:0] {
      MEM_IDLE  = 2'd0,
      MEM_WRITE = 2'd1,
      MEM_READ  = 2'd2
   } mem_op_e;

   // request bundle from controller to arbiter
   typedef struct packed {
      logic                    wr_req;
      logic                    rd_req;
      logic [`FIFO_ADDR_W-1:0] wr_addr;
      logic [`FIFO_ADDR_W-1:0] rd_addr;
      fifo_word_t              wr_data;
   } mem_req_t;

   // round-robin memory, which side won last
   typedef enum logic {
      ARB_LAST_WR = 1'b0,
      ARB_LAST_RD = 1'b1
   } arb_state_e;

endpackage

`default_nettype wire

// File: fifo_mem_arbiter.sv
// one port per cycle; read data is registered and valid one cycle after a read grant
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_mem_arbiter (
   input  logic                 pos_rclk,
   input  logic                 aresetn_rclk,
   input  fifo_pkg::mem_req_t   req,
   output fifo_pkg::mem_op_e    grant,
   output fifo_pkg::fifo_word_t rd_data,
   output logic                 rd_dvld
);

   import fifo_pkg::*;

   // --------------------------------------------------
   // storage and arbitration state
   // --------------------------------------------------

   // single-port array, one access per edge
   fifo_word_t mem [0:`FIFO_DEPTH-1];

   // side that won the previous contested or single grant
   arb_state_e last_q;

   // --------------------------------------------------
   // grant decision
   // --------------------------------------------------

   // lone request always wins
   // on contention the side that did not win last time goes
   always_comb begin
      grant = MEM_IDLE;
      if (req.wr_req && req.rd_req) begin
         if (last_q == ARB_LAST_WR) begin
            grant = MEM_READ;
         end else begin
            grant = MEM_WRITE;
         end
      end else if (req.wr_req) begin
         grant = MEM_WRITE;
      end else if (req.rd_req) begin
         grant = MEM_READ;
      end
   end

   // remember winner for next contention
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         last_q <= ARB_LAST_RD;
      end else begin
         if (grant == MEM_WRITE) begin
            last_q <= ARB_LAST_WR;
         end else if (grant == MEM_READ) begin
            last_q <= ARB_LAST_RD;
         end
      end
   end

   // --------------------------------------------------
   // memory port
   // --------------------------------------------------

   // write and read share the one port, grant picks which address
   always_ff @(posedge pos_rclk) begin
      if (grant == MEM_WRITE) begin
         mem[req.wr_addr] <= req.wr_data;
      end
      // read word holds until the next read grant
      if (grant == MEM_READ) begin
         rd_data <= mem[req.rd_addr];
      end
   end

   // data valid pulse, one cycle behind the read grant
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         rd_dvld <= 1'b0;
      end else begin
         rd_dvld <= (grant == MEM_READ);
      end
   end

endmodule

`default_nettype wire

// File: fifo_ctrl.sv
// counts words in ram only; words already handed to the output stage are not included
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_ctrl (
   input  logic                 pos_rclk,
   input  logic                 aresetn_rclk,
   input  logic                 in_valid,
   input  fifo_pkg::fifo_word_t in_data,
   output logic                 in_ready,
   input  logic                 fetch_req,
   input  fifo_pkg::mem_op_e    grant,
   output fifo_pkg::mem_req_t   req
);

   import fifo_pkg::*;

   // full level at count width
   localparam logic [`FIFO_ADDR_W:0] DEPTH_C = (`FIFO_ADDR_W + 1)'(`FIFO_DEPTH);

   // --------------------------------------------------
   // pointers and fill level
   // --------------------------------------------------

   logic [`FIFO_ADDR_W-1:0] wr_ptr;
   logic [`FIFO_ADDR_W-1:0] rd_ptr;
   // one extra bit so that full and empty differ
   logic [`FIFO_ADDR_W:0]   count;
   // writes held off until the first edge out of reset
   logic                    wr_en_q;

   logic full;
   logic empty;

   assign full  = (count == DEPTH_C);
   assign empty = (count == '0);

   // --------------------------------------------------
   // requests toward the arbiter
   // --------------------------------------------------

   // write only when there is room
   // read only when a word sits in ram
   always_comb begin
      req.wr_req  = in_valid & ~full & wr_en_q;
      req.rd_req  = fetch_req & ~empty;
      req.wr_addr = wr_ptr;
      req.rd_addr = rd_ptr;
      req.wr_data = in_data;
   end

   // handshake completes only on a write grant
   assign in_ready = (grant == MEM_WRITE);

   // --------------------------------------------------
   // pointer update
   // --------------------------------------------------

   // single port, so at most one side moves per edge
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         wr_en_q <= 1'b0;
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
      end else begin
         wr_en_q <= 1'b1;
         case (grant)
            MEM_WRITE: begin
               wr_ptr <= wr_ptr + 1'b1;
               count  <= count + 1'b1;
            end
            MEM_READ: begin
               rd_ptr <= rd_ptr + 1'b1;
               count  <= count - 1'b1;
            end
            default: begin
               // idle cycle, nothing moves
               count <= count;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: fifo_fwft.sv
// holds up to three words outside ram; relies on rd_data holding until the next read grant
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_fwft (
   input  logic                 pos_rclk,
   input  logic                 aresetn_rclk,
   input  fifo_pkg::fifo_word_t rd_data,
   input  logic                 rd_dvld,
   output logic                 fetch_req,
   output logic                 out_valid,
   output fifo_pkg::fifo_word_t out_data,
   input  logic                 out_ready
);

   import fifo_pkg::*;

   // --------------------------------------------------
   // slot state
   // --------------------------------------------------

   // word parked on rd_data, not yet taken
   logic       held_q;
   logic       middle_valid;
   fifo_word_t middle_data;
   logic       dout_valid;
   // requests held off for one cycle out of reset
   logic       armed_q;

   logic fifo_valid;
   logic pop;
   logic update_dout;
   logic update_middle;

   // in-flight slot is fresh data or data still waiting
   assign fifo_valid = rd_dvld | held_q;
   assign pop        = dout_valid & out_ready;

   // output register refills whenever it is empty or being drained
   assign update_dout   = (fifo_valid | middle_valid) & (pop | ~dout_valid);
   // middle takes memory data when output is busy, or when middle itself moves on
   assign update_middle = fifo_valid & (middle_valid == update_dout);

   // stop once all three slots are taken
   // a grant shows up as rd_dvld next cycle, so one read is in flight at most
   assign fetch_req = armed_q & ~(dout_valid & middle_valid & fifo_valid);

   assign out_valid = dout_valid;

   // --------------------------------------------------
   // control flags
   // --------------------------------------------------

   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         armed_q      <= 1'b0;
         held_q       <= 1'b0;
         middle_valid <= 1'b0;
         dout_valid   <= 1'b0;
      end else begin
         armed_q <= 1'b1;
         // memory word stays parked unless middle or output took it
         held_q  <= fifo_valid & ~(update_middle | update_dout);

         if (update_middle) begin
            middle_valid <= 1'b1;
         end else if (update_dout) begin
            middle_valid <= 1'b0;
         end

         if (update_dout) begin
            dout_valid <= 1'b1;
         end else if (pop) begin
            dout_valid <= 1'b0;
         end
      end
   end

   // --------------------------------------------------
   // payload
   // --------------------------------------------------

   // middle goes first to keep order
   always_ff @(posedge pos_rclk) begin
      if (update_middle) begin
         middle_data <= rd_data;
      end
      if (update_dout) begin
         out_data <= middle_valid ? middle_data : rd_data;
      end
   end

endmodule

`default_nettype wire

// File: fifo_top.sv
// single clock; first word visible at least three cycles after it enters an empty FIFO
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_top (
   input  logic                 pos_rclk,
   input  logic                 aresetn_rclk,
   input  logic                 in_valid,
   input  fifo_pkg::fifo_word_t in_data,
   output logic                 in_ready,
   output logic                 out_valid,
   output fifo_pkg::fifo_word_t out_data,
   input  logic                 out_ready
);

   import fifo_pkg::*;

   // --------------------------------------------------
   // internal nets
   // --------------------------------------------------

   mem_req_t   req;
   mem_op_e    grant;
   fifo_word_t rd_data;
   logic       rd_dvld;
   logic       fetch_req;

   // pointers, count, request generation
   fifo_ctrl i_fifo_ctrl (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .in_valid     (in_valid),
      .in_data      (in_data),
      .in_ready     (in_ready),
      .fetch_req    (fetch_req),
      .grant        (grant),
      .req          (req)
   );

   // ram plus round-robin port sharing
   fifo_mem_arbiter i_fifo_mem_arbiter (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .req          (req),
      .grant        (grant),
      .rd_data      (rd_data),
      .rd_dvld      (rd_dvld)
   );

   // look-ahead output stage
   fifo_fwft i_fifo_fwft (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .rd_data      (rd_data),
      .rd_dvld      (rd_dvld),
      .fetch_req    (fetch_req),
      .out_valid    (out_valid),
      .out_data     (out_data),
      .out_ready    (out_ready)
   );

endmodule

`default_nettype wire

// File: fifo_properties.sv
// bound to fifo_top; occupancy counted from port handshakes only
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_properties (
   input wire logic                 pos_rclk,
   input wire logic                 aresetn_rclk,
   input wire logic                 in_valid,
   input wire logic                 in_ready,
   input wire logic                 out_valid,
   input wire fifo_pkg::fifo_word_t out_data,
   input wire logic                 out_ready
);

   import fifo_pkg::*;

   // words inside the FIFO, ram plus the three output slots
   int occupancy;

   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         occupancy <= 0;
      end else begin
         occupancy <= occupancy + int'(in_valid & in_ready) - int'(out_valid & out_ready);
      end
   end

   // nothing moves while reset is held
   no_ready_in_reset: assert property (@(posedge pos_rclk) !aresetn_rclk |-> !in_ready)
      else $error("in_ready high during reset");
   no_valid_in_reset: assert property (@(posedge pos_rclk) !aresetn_rclk |-> !out_valid)
      else $error("out_valid high during reset");

   // stalled head word stays put
   hold_when_stalled: assert property (@(posedge pos_rclk) disable iff (!aresetn_rclk)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
      else $error("output changed while stalled");

   occupancy_bound: assert property (@(posedge pos_rclk) disable iff (!aresetn_rclk)
      occupancy <= `FIFO_DEPTH + 3)
      else $error("more words held than the FIFO can store");

endmodule

bind fifo_top fifo_properties i_fifo_properties (
   .pos_rclk     (pos_rclk),
   .aresetn_rclk (aresetn_rclk),
   .in_valid     (in_valid),
   .in_ready     (in_ready),
   .out_valid    (out_valid),
   .out_data     (out_data),
   .out_ready    (out_ready)
);

`default_nettype wire

// File: tb_fifo.sv
// single clock FWFT FIFO testbench; expects FIFO_DEPTH plus 3 words of capacity under stall
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module tb_fifo;

   import fifo_pkg::*;

   localparam int SEED        = 33806;
   localparam int BURST_WORDS = 20;
   localparam int RAND_CYCLES = 400;
   localparam int QUIET_WIN   = 50;
   localparam int WAIT_LIMIT  = 600;
   localparam int CAPACITY    = `FIFO_DEPTH + 3;

   logic       pos_rclk;
   logic       aresetn_rclk;
   logic       in_valid;
   fifo_word_t in_data;
   logic       in_ready;
   logic       out_valid;
   fifo_word_t out_data;
   logic       out_ready;

   // reference model of the stored words
   fifo_word_t model_q[$];
   logic [15:0] lfsr;
   string       test_name;
   logic        in_fire;
   int          accepted;

   fifo_top i_fifo_top (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .in_valid     (in_valid),
      .in_data      (in_data),
      .in_ready     (in_ready),
      .out_valid    (out_valid),
      .out_data     (out_data),
      .out_ready    (out_ready)
   );

   // 8 ns period
   always #4 pos_rclk = ~pos_rclk;

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------

   // galois form, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic take_bit(output logic b);
      lfsr = lfsr_next(lfsr);
      b    = lfsr[0];
   endtask

   task automatic take_word(output fifo_word_t w);
      logic b;
      for (int i = 0; i < `FIFO_DATA_W; i++) begin
         take_bit(b);
         w[i] = b;
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   // drive on the falling edge, sample settled handshakes before the rising edge
   task automatic run_cycle(input logic v, input fifo_word_t d, input logic r);
      fifo_word_t exp;
      @(negedge pos_rclk);
      in_valid  = v;
      in_data   = d;
      out_ready = r;
      #1;
      in_fire = in_valid & in_ready;
      if (in_fire) begin
         model_q.push_back(in_data);
         accepted++;
      end
      if (out_valid && out_ready) begin
         if (model_q.size() == 0) begin
            abort_run($sformatf("%s: output word with nothing written", test_name));
         end
         exp = model_q.pop_front();
         assert (out_data == exp) else begin
            $display("Error %s: expected %h actual %h", test_name, exp, out_data);
            abort_run("data mismatch on output stream");
         end
      end
   endtask

   task automatic drain_all();
      int cycles;
      cycles = 0;
      while (model_q.size() != 0) begin
         run_cycle(1'b0, '0, 1'b1);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_run($sformatf("%s: drain timed out with words left", test_name));
         end
      end
   endtask

   // offer words in order, holding data until taken
   task automatic push_words(input int n, input logic r);
      int sent;
      int cycles;
      sent   = 0;
      cycles = 0;
      while (sent < n) begin
         run_cycle(1'b1, fifo_word_t'(16'h1000 + sent), r);
         if (in_fire) begin
            sent++;
         end
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_run($sformatf("%s: input stream stuck", test_name));
         end
      end
   endtask

   // --------------------------------------------------
   // sequence
   // --------------------------------------------------

   initial begin
      int quiet;
      int cycles;
      logic v;
      logic r;
      fifo_word_t d;
      pos_rclk     = 1'b0;
      aresetn_rclk = 1'b0;
      in_valid     = 1'b0;
      in_data      = '0;
      out_ready    = 1'b0;
      lfsr         = 16'(SEED);
      accepted     = 0;

      // source and sink already active while reset is held
      test_name = "reset";
      for (int i = 0; i < 8; i++) begin
         run_cycle(1'b1, '1, 1'b1);
         assert (!out_valid && !in_ready) else begin
            abort_run("outputs active while reset is held");
         end
      end
      @(negedge pos_rclk);
      aresetn_rclk = 1'b1;
      in_valid     = 1'b0;
      run_cycle(1'b0, '0, 1'b0);
      assert (!out_valid && !in_ready) else begin
         abort_run("outputs active right after reset");
      end

      test_name = "ordering";
      push_words(BURST_WORDS, 1'b1);
      drain_all();

      // stalled sink, keep offering until input goes quiet
      test_name = "capacity";
      accepted  = 0;
      quiet     = 0;
      cycles    = 0;
      while (quiet < QUIET_WIN) begin
         run_cycle(1'b1, fifo_word_t'(16'h2000 + accepted), 1'b0);
         quiet = in_fire ? 0 : quiet + 1;
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_run("capacity: input never stayed blocked");
         end
      end
      assert (accepted == CAPACITY) else begin
         $display("Error %s: expected %0d actual %0d", test_name, CAPACITY, accepted);
         abort_run("wrong number of words accepted");
      end
      drain_all();

      test_name = "random";
      v = 1'b0;
      d = '0;
      for (int i = 0; i < RAND_CYCLES; i++) begin
         // source keeps valid and data until the word is taken
         if (!v || in_fire) begin
            take_bit(v);
            take_word(d);
         end
         take_bit(r);
         run_cycle(v, d, r);
      end
      drain_all();
      run_cycle(1'b0, '0, 1'b1);
      assert (!out_valid) else begin
         abort_run("random: output still valid after final drain");
      end

      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
fifo_pkg.sv
fifo_mem_arbiter.sv
fifo_ctrl.sv
fifo_fwft.sv
fifo_top.sv
fifo_properties.sv
tb_fifo.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wall -Wno-fatal --top-module tb_fifo -f flist.f
out=$(./obj_dir/Vtb_fifo 2>&1) || true
echo "$out"
if echo "$out" | grep -q "PASS: all tests"; then
   exit 0
else
   exit 1
fi
